//--- Bender.yml
package:
  name: riscv_pipe

sources:
  - include_dirs:
      - src
    files:
      - src/rv_isa_pkg.sv
      - src/rv_pipe_pkg.sv
      - src/rv_pipe_if.sv
      - src/fetch_stage.sv
      - src/decode_control.sv
      - src/execute_stage.sv
      - src/mem_wb_stage.sv
      - src/riscv_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_riscv_top.sv

//--- filelist.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_pipe_if.sv
src/fetch_stage.sv
src/decode_control.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/riscv_top.sv
tests/tb_riscv_top.sv

//--- src/decode_control.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_control import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic      CLK,
	input  logic      RSTn,
	fd_if.decode      fd,
	de_if.decode      de,
	input  logic      redirect,
	input  logic      halted,
	output reg_addr_t rf_ra1,
	output reg_addr_t rf_ra2,
	input  word_t     rf_rd1,
	input  word_t     rf_rd2,
	input  logic      wb_we,
	input  reg_addr_t wb_rd,
	input  word_t     wb_value,
	output logic      stall
);
	logic       if_valid;	// decode input register
	imem_addr_t if_pc;
	word_t      if_instr;
	logic       halt_seen;	// ebreak issued, nothing younger goes on
	opcode_t    opcode;
	funct3_t    funct3;
	funct7_t    funct7;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm;
	word_t      rs1_val;
	word_t      rs2_val;
	logic       use_imm;
	logic       uses_rs1;
	logic       uses_rs2;
	logic       mem_rd;
	logic       mem_wr;
	logic       reg_we;
	logic       halt_d;
	alu_op_t    alu_op;
	wb_sel_t    wb_sel;
	br_kind_t   br_kind;
	logic       flush;
	logic       issue;

	assign opcode = opcode_t'(if_instr[6:0]);
	assign funct3 = if_instr[14:12];
	assign funct7 = if_instr[31:25];
	assign rs1    = if_instr[19:15];
	assign rs2    = if_instr[24:20];
	assign rd     = if_instr[11:7];

	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
		if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
		if_instr[30:21], 1'b0};

	always_comb begin
		imm      = '0;
		use_imm  = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		mem_rd   = 1'b0;
		mem_wr   = 1'b0;
		reg_we   = 1'b0;
		halt_d   = 1'b0;
		alu_op   = ALU_ADD;
		wb_sel   = WB_ALU;
		br_kind  = BR_NONE;
		case (opcode)
			OPC_OP: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				reg_we   = 1'b1;
				case ({funct7, funct3})
					{F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
					{F7_SUB, F3_ADD_SUB}:  alu_op = ALU_SUB;
					{F7_BASE, F3_SLT}:     alu_op = ALU_SLT;
					{F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
					{F7_BASE, F3_OR}:      alu_op = ALU_OR;
					{F7_BASE, F3_AND}:     alu_op = ALU_AND;
					default:               reg_we = 1'b0;	// not in the subset
				endcase
			end
			OPC_OP_IMM: if (funct3 == F3_ADD_SUB) begin	// addi only
				uses_rs1 = 1'b1;
				use_imm  = 1'b1;
				imm      = imm_i;
				reg_we   = 1'b1;
			end
			OPC_LOAD: if (funct3 == F3_WORD) begin
				uses_rs1 = 1'b1;
				use_imm  = 1'b1;
				imm      = imm_i;
				mem_rd   = 1'b1;
				reg_we   = 1'b1;
				wb_sel   = WB_MEM;
			end
			OPC_STORE: if (funct3 == F3_WORD) begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				use_imm  = 1'b1;
				imm      = imm_s;
				mem_wr   = 1'b1;
			end
			OPC_BRANCH: if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				imm      = imm_b;
				br_kind  = (funct3 == F3_BEQ) ? BR_BEQ : BR_BNE;
			end
			OPC_JAL: begin
				imm     = imm_j;
				br_kind = BR_JAL;
				reg_we  = 1'b1;
				wb_sel  = WB_LINK;
			end
			OPC_SYSTEM: halt_d = (if_instr == `RV_HALT_INSN);
			default: ;
		endcase
	end

	assign rf_ra1 = rs1;
	assign rf_ra2 = rs2;

	// a write landing this cycle is not yet in the array read
	assign rs1_val = (wb_we && wb_rd == rs1) ? wb_value : rf_rd1;
	assign rs2_val = (wb_we && wb_rd == rs2) ? wb_value : rf_rd2;

	// load in execute feeding this instruction
	assign stall = if_valid && de.valid && de.mem_rd && de.rd != '0 &&
		((uses_rs1 && de.rd == rs1) || (uses_rs2 && de.rd == rs2));

	assign flush = redirect || halted || halt_seen;
	assign issue = if_valid && !stall && !flush;

	always_ff @(posedge CLK) begin
		if (RSTn)
			if_valid <= 1'b0;
		else if (flush)
			if_valid <= 1'b0;
		else if (!stall)
			if_valid <= fd.valid;
	end

	always_ff @(posedge CLK) begin
		if (flush) begin
			if_instr <= `RV_NOP_INSN;
		end else if (!stall) begin
			if_pc    <= fd.pc;
			if_instr <= fd.instr;
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			de.valid  <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			de.valid <= issue;	// bubble on stall or flush
			if (issue && halt_d)
				halt_seen <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		de.pc       <= if_pc;
		de.rs1      <= rs1;
		de.rs2      <= rs2;
		de.rd       <= rd;
		de.rs1_data <= rs1_val;
		de.rs2_data <= rs2_val;
		de.imm      <= imm;
		de.use_imm  <= use_imm;
		de.alu_op   <= alu_op;
		de.br_kind  <= br_kind;
		de.mem_rd   <= mem_rd;
		de.mem_wr   <= mem_wr;
		de.reg_we   <= reg_we;
		de.wb_sel   <= wb_sel;
		de.halt     <= halt_d;
	end

	// the bubble clears the load from execute so one cycle is enough
	a_single_stall: assert property (@(posedge CLK) disable iff (RSTn)
		stall |=> !stall);

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic       CLK,
	input  logic       RSTn,
	de_if.execute      de,
	em_if.execute      em,
	input  logic       fwd_mem_we,
	input  reg_addr_t  fwd_mem_rd,
	input  word_t      fwd_mem_value,
	input  logic       fwd_wb_we,
	input  reg_addr_t  fwd_wb_rd,
	input  word_t      fwd_wb_value,
	output logic       redirect,
	output imem_addr_t redirect_pc
);
	fwd_sel_t sel_a;
	fwd_sel_t sel_b;
	word_t    op_a;
	word_t    op_b;	// rs2 after forwarding, also the store data
	word_t    alu_b;
	word_t    alu_y;
	logic     taken;

	// memory stage holds the younger value so it is checked first
	function automatic fwd_sel_t fwd_pick(input reg_addr_t rs);
		if (rs != '0 && fwd_mem_we && fwd_mem_rd == rs)
			return FWD_MEM;
		if (rs != '0 && fwd_wb_we && fwd_wb_rd == rs)
			return FWD_WB;
		return FWD_REG;
	endfunction

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
		case (sel)
			FWD_MEM: return fwd_mem_value;
			FWD_WB:  return fwd_wb_value;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		sel_a = fwd_pick(de.rs1);
		sel_b = fwd_pick(de.rs2);
		op_a  = fwd_mux(sel_a, de.rs1_data);
		op_b  = fwd_mux(sel_b, de.rs2_data);
		alu_b = de.use_imm ? de.imm : op_b;
	end

	always_comb begin
		case (de.alu_op)
			ALU_ADD: alu_y = op_a + alu_b;
			ALU_SUB: alu_y = op_a - alu_b;
			ALU_AND: alu_y = op_a & alu_b;
			ALU_OR:  alu_y = op_a | alu_b;
			ALU_XOR: alu_y = op_a ^ alu_b;
			ALU_SLT: alu_y = {31'b0, $signed(op_a) < $signed(alu_b)};
			default: alu_y = op_a + alu_b;
		endcase
	end

	// branch compare on the forwarded registers
	always_comb begin
		case (de.br_kind)
			BR_BEQ:  taken = (op_a == op_b);
			BR_BNE:  taken = (op_a != op_b);
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect    = de.valid && taken;
	assign redirect_pc = de.pc + imem_addr_t'(de.imm);	// pc relative target

	always_ff @(posedge CLK) begin
		if (RSTn)
			em.valid <= 1'b0;
		else
			em.valid <= de.valid;
	end

	always_ff @(posedge CLK) begin
		em.rd         <= de.rd;
		em.result     <= alu_y;
		em.store_data <= op_b;
		em.mem_rd     <= de.mem_rd;
		em.mem_wr     <= de.mem_wr;
		em.reg_we     <= de.reg_we;
		em.wb_sel     <= de.wb_sel;
		em.link_pc    <= de.pc + imem_addr_t'(4);	// jal return address
		em.halt       <= de.halt;
	end

	// decode answers a redirect with a bubble in the next cycle
	a_redirect_flush: assert property (@(posedge CLK) disable iff (RSTn)
		redirect |-> de.valid ##1 !de.valid);

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module fetch_stage import rv_isa_pkg::*; (
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       stall,
	input  logic       redirect,
	input  imem_addr_t redirect_pc,
	input  logic       halted,
	output logic       i_mem_csn,
	output imem_addr_t i_mem_addr,
	input  word_t      i_mem_di,
	fd_if.fetch        fd
);
	imem_addr_t pc;
	logic       fetch_en;	// low in reset and once halted

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc       <= imem_addr_t'(`RV_RESET_PC);
			fetch_en <= 1'b0;
		end else if (halted) begin
			fetch_en <= 1'b0;	// pc frozen from here on
		end else begin
			fetch_en <= 1'b1;
			if (redirect)
				pc <= redirect_pc;	// wins over a stall
			else if (fetch_en && !stall)
				pc <= pc + imem_addr_t'(4);
		end
	end

	assign i_mem_csn  = !fetch_en || halted;
	assign i_mem_addr = pc;

	// decode samples the memory output in the same cycle
	assign fd.valid = fetch_en && !halted;
	assign fd.pc    = pc;
	assign fd.instr = i_mem_di;

	// the drain after ebreak leaves nothing in execute that could branch
	a_no_redirect_halted: assert property (@(posedge CLK) disable iff (RSTn)
		halted |-> !redirect);

endmodule

//--- src/mem_wb_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module mem_wb_stage import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic       CLK,
	input  logic       RSTn,
	em_if.mem          em,
	output logic       d_mem_csn,
	output logic       d_mem_wen,
	output dmem_addr_t d_mem_addr,
	output word_t      d_mem_dout,
	output logic [3:0] d_mem_be,
	input  word_t      d_mem_di,
	output logic       rf_we,
	output reg_addr_t  rf_wa1,
	output word_t      rf_wd,
	output logic       fwd_mem_we,
	output reg_addr_t  fwd_mem_rd,
	output word_t      fwd_mem_value,
	output logic       fwd_wb_we,
	output reg_addr_t  fwd_wb_rd,
	output word_t      fwd_wb_value,
	output logic       halted,
	output word_t      num_inst
);
	word_t     mem_value;	// value handed on to writeback
	logic      wb_valid;
	logic      wb_we;
	reg_addr_t wb_rd;
	word_t     wb_value;

	assign d_mem_csn  = !(em.valid && (em.mem_rd || em.mem_wr));
	assign d_mem_wen  = !(em.valid && em.mem_wr);
	assign d_mem_addr = em.result[`RV_DMEM_AW+1:2];	// byte to word address
	assign d_mem_dout = em.store_data;
	assign d_mem_be   = 4'b1111;	// word accesses only

	always_comb begin
		case (em.wb_sel)
			WB_MEM:  mem_value = d_mem_di;
			WB_LINK: mem_value = word_t'(em.link_pc);
			default: mem_value = em.result;
		endcase
	end

	assign fwd_mem_we    = em.valid && em.reg_we && em.rd != '0;
	assign fwd_mem_rd    = em.rd;
	assign fwd_mem_value = mem_value;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wb_valid <= 1'b0;
			halted   <= 1'b0;
			num_inst <= '0;
		end else begin
			wb_valid <= em.valid;
			if (em.valid) begin
				num_inst <= num_inst + 1'b1;	// counted as it enters writeback
				if (em.halt)
					halted <= 1'b1;	// sticky until reset
			end
		end
	end

	always_ff @(posedge CLK) begin
		wb_we    <= em.reg_we && em.rd != '0;	// x0 stays zero
		wb_rd    <= em.rd;
		wb_value <= mem_value;
	end

	assign rf_we  = wb_valid && wb_we;
	assign rf_wa1 = wb_rd;
	assign rf_wd  = wb_value;

	assign fwd_wb_we    = rf_we;
	assign fwd_wb_rd    = wb_rd;
	assign fwd_wb_value = wb_value;

	// nothing younger than the ebreak may write back
	a_rf_write: assert property (@(posedge CLK) disable iff (RSTn)
		rf_we |-> rf_wa1 != '0 && !$past(halted));

endmodule

//--- src/riscv_top.sv
`timescale 1ns/1ps

module riscv_top import rv_isa_pkg::*; (
	input  logic       CLK,
	input  logic       RSTn,

	output logic       i_mem_csn,
	input  word_t      i_mem_di,
	output imem_addr_t i_mem_addr,	// byte address

	output logic       d_mem_csn,
	input  word_t      d_mem_di,
	output word_t      d_mem_dout,
	output dmem_addr_t d_mem_addr,	// word address
	output logic       d_mem_wen,
	output logic [3:0] d_mem_be,

	output logic       rf_we,
	output reg_addr_t  rf_ra1,
	output reg_addr_t  rf_ra2,
	output reg_addr_t  rf_wa1,
	input  word_t      rf_rd1,
	input  word_t      rf_rd2,
	output word_t      rf_wd,
	output logic       halt,
	output word_t      num_inst
);
	fd_if fd ();
	de_if de ();
	em_if em ();

	logic       stall;
	logic       redirect;
	imem_addr_t redirect_pc;
	logic       fwd_mem_we;
	reg_addr_t  fwd_mem_rd;
	word_t      fwd_mem_value;
	logic       fwd_wb_we;
	reg_addr_t  fwd_wb_rd;
	word_t      fwd_wb_value;

	fetch_stage u_fetch (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halted      (halt),
		.i_mem_csn   (i_mem_csn),
		.i_mem_addr  (i_mem_addr),
		.i_mem_di    (i_mem_di),
		.fd          (fd.fetch)
	);

	decode_control u_decode (
		.CLK      (CLK),
		.RSTn     (RSTn),
		.fd       (fd.decode),
		.de       (de.decode),
		.redirect (redirect),
		.halted   (halt),
		.rf_ra1   (rf_ra1),
		.rf_ra2   (rf_ra2),
		.rf_rd1   (rf_rd1),
		.rf_rd2   (rf_rd2),
		.wb_we    (rf_we),	// same-cycle write bypass
		.wb_rd    (rf_wa1),
		.wb_value (rf_wd),
		.stall    (stall)
	);

	execute_stage u_execute (
		.CLK           (CLK),
		.RSTn          (RSTn),
		.de            (de.execute),
		.em            (em.execute),
		.fwd_mem_we    (fwd_mem_we),
		.fwd_mem_rd    (fwd_mem_rd),
		.fwd_mem_value (fwd_mem_value),
		.fwd_wb_we     (fwd_wb_we),
		.fwd_wb_rd     (fwd_wb_rd),
		.fwd_wb_value  (fwd_wb_value),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc)
	);

	mem_wb_stage u_mem_wb (
		.CLK           (CLK),
		.RSTn          (RSTn),
		.em            (em.mem),
		.d_mem_csn     (d_mem_csn),
		.d_mem_wen     (d_mem_wen),
		.d_mem_addr    (d_mem_addr),
		.d_mem_dout    (d_mem_dout),
		.d_mem_be      (d_mem_be),
		.d_mem_di      (d_mem_di),
		.rf_we         (rf_we),
		.rf_wa1        (rf_wa1),
		.rf_wd         (rf_wd),
		.fwd_mem_we    (fwd_mem_we),
		.fwd_mem_rd    (fwd_mem_rd),
		.fwd_mem_value (fwd_mem_value),
		.fwd_wb_we     (fwd_wb_we),
		.fwd_wb_rd     (fwd_wb_rd),
		.fwd_wb_value  (fwd_wb_value),
		.halted        (halt),
		.num_inst      (num_inst)
	);

endmodule

//--- src/rv_isa_pkg.sv
`include "rv_macros.svh"

package rv_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;	// byte pc
	typedef logic [`RV_DMEM_AW-1:0] dmem_addr_t;	// word index
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// major opcodes of the subset
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;
	localparam funct3_t F3_WORD    = 3'b010;	// lw and sw
	localparam funct3_t F3_BEQ     = 3'b000;
	localparam funct3_t F3_BNE     = 3'b001;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_SUB  = 7'b0100000;

endpackage

//--- src/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// address widths of the two memories
`define RV_IMEM_AW 12	// byte address
`define RV_DMEM_AW 12	// word address

// first fetch address after reset
`define RV_RESET_PC 0

// ebreak stops the core
`define RV_HALT_INSN 32'h0010_0073

// addi x0, x0, 0
`define RV_NOP_INSN 32'h0000_0013

`endif

//--- src/rv_pipe_if.sv
`timescale 1ns/1ps

// instr is the raw instruction memory output
interface fd_if import rv_isa_pkg::*; ();
	logic       valid;
	imem_addr_t pc;
	word_t      instr;

	modport fetch (output valid, pc, instr);
	modport decode (input valid, pc, instr);
endinterface

interface de_if import rv_isa_pkg::*, rv_pipe_pkg::*; ();
	logic       valid;
	imem_addr_t pc;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	word_t      rs1_data;
	word_t      rs2_data;
	word_t      imm;
	logic       use_imm;
	alu_op_t    alu_op;
	br_kind_t   br_kind;
	logic       mem_rd;
	logic       mem_wr;
	logic       reg_we;
	wb_sel_t    wb_sel;
	logic       halt;

	modport decode (output valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, use_imm,
		alu_op, br_kind, mem_rd, mem_wr, reg_we, wb_sel, halt);
	modport execute (input valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, use_imm,
		alu_op, br_kind, mem_rd, mem_wr, reg_we, wb_sel, halt);
endinterface

interface em_if import rv_isa_pkg::*, rv_pipe_pkg::*; ();
	logic       valid;
	reg_addr_t  rd;
	word_t      result;		// alu output, byte address for lw/sw
	word_t      store_data;
	logic       mem_rd;
	logic       mem_wr;
	logic       reg_we;
	wb_sel_t    wb_sel;
	imem_addr_t link_pc;
	logic       halt;

	modport execute (output valid, rd, result, store_data, mem_rd, mem_wr, reg_we,
		wb_sel, link_pc, halt);
	modport mem (input valid, rd, result, store_data, mem_rd, mem_wr, reg_we,
		wb_sel, link_pc, halt);
endinterface

//--- src/rv_pipe_pkg.sv
package rv_pipe_pkg;

	// alu function picked in decode
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

	// source of the writeback value
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK	// pc + 4 for jal
	} wb_sel_t;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// control transfer resolved in execute
	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_JAL
	} br_kind_t;

endpackage

//--- tests/tb_riscv_top.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_riscv_top import rv_isa_pkg::*; ();
	localparam int N_INSN     = 60;
	localparam int IMEM_WORDS = 1 << (`RV_IMEM_AW - 2);
	localparam int DMEM_WORDS = 1 << `RV_DMEM_AW;
	localparam int TIMEOUT    = 2000;

	typedef enum int {
		K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
		K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_HALT
	} kind_t;

	logic       CLK;
	logic       RSTn;
	logic       i_mem_csn;
	word_t      i_mem_di;
	imem_addr_t i_mem_addr;
	logic       d_mem_csn;
	word_t      d_mem_di;
	word_t      d_mem_dout;
	dmem_addr_t d_mem_addr;
	logic       d_mem_wen;
	logic [3:0] d_mem_be;
	logic       rf_we;
	reg_addr_t  rf_ra1;
	reg_addr_t  rf_ra2;
	reg_addr_t  rf_wa1;
	word_t      rf_rd1;
	word_t      rf_rd2;
	word_t      rf_wd;
	logic       halt;
	word_t      num_inst;

	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	word_t rf [32];

	// program kept as fields for the model
	kind_t     p_kind [N_INSN];
	reg_addr_t p_rd [N_INSN];
	reg_addr_t p_rs1 [N_INSN];
	reg_addr_t p_rs2 [N_INSN];
	word_t     p_imm [N_INSN];

	logic [31:0] rng;
	reg_addr_t   exp_rd [$];	// expected register writes in order
	word_t       exp_wval [$];
	dmem_addr_t  exp_saddr [$];	// expected stores in order
	word_t       exp_sdata [$];
	word_t       exp_count;
	int          value_errs;
	int          other_errs;

	riscv_top u_riscv_top (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// rv32i base encodings
	function automatic word_t encode(input kind_t k, input reg_addr_t rd, input reg_addr_t rs1,
			input reg_addr_t rs2, input word_t imm);
		case (k)
			K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
			K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			K_SLT:   return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
			K_LW:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
			K_SW:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
			K_BEQ:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
			K_BNE:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
			K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
			default: return `RV_HALT_INSN;
		endcase
	endfunction

	task automatic build_program();
		logic [31:0] r;
		int          k;
		for (int a = 0; a < IMEM_WORDS; a++)
			imem[a] = `RV_NOP_INSN;	// fetched past the end but never retired
		for (int i = 0; i < N_INSN; i++) begin
			rng = xorshift(rng);
			r = rng;
			p_kind[i] = (i == N_INSN - 1) ? K_HALT : kind_t'(r[19:12] % 12);
			p_rd[i]   = reg_addr_t'(r[2:0]);	// x0..x7 only
			p_rs1[i]  = reg_addr_t'(r[5:3]);
			p_rs2[i]  = reg_addr_t'(r[8:6]);
			p_imm[i]  = {{20{r[31]}}, r[31:20]};
			if (p_kind[i] == K_LW || p_kind[i] == K_SW) begin
				p_rs1[i] = '0;	// absolute word 0..15
				p_imm[i] = word_t'(r[24:21]) << 2;
			end else if (p_kind[i] inside {K_BEQ, K_BNE, K_JAL}) begin
				k = 1 + r[10:9];	// forward only
				if (i + k > N_INSN - 1)
					k = N_INSN - 1 - i;
				p_imm[i] = word_t'(k * 4);
			end
			imem[i] = encode(p_kind[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
		end
	endtask

	task automatic run_model();
		word_t m_reg [32];
		word_t m_dmem [16];
		word_t a;
		word_t b;
		word_t v;
		logic  wr;
		logic  jump;
		logic  done;
		int    pc;
		for (int r = 0; r < 32; r++)
			m_reg[r] = '0;
		for (int w = 0; w < 16; w++)
			m_dmem[w] = dmem[w];
		pc = 0;
		done = 1'b0;
		exp_count = '0;
		while (!done && pc < N_INSN) begin
			a = m_reg[p_rs1[pc]];
			b = m_reg[p_rs2[pc]];
			v = '0;
			wr = 1'b1;
			jump = 1'b0;
			exp_count = exp_count + 1;
			case (p_kind[pc])
				K_ADDI: v = a + p_imm[pc];
				K_ADD:  v = a + b;
				K_SUB:  v = a - b;
				K_AND:  v = a & b;
				K_OR:   v = a | b;
				K_XOR:  v = a ^ b;
				K_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				K_LW:   v = m_dmem[p_imm[pc][5:2]];
				K_SW: begin
					wr = 1'b0;
					m_dmem[p_imm[pc][5:2]] = b;
					exp_saddr.push_back(dmem_addr_t'(p_imm[pc][5:2]));
					exp_sdata.push_back(b);
				end
				K_BEQ: begin
					wr = 1'b0;
					jump = (a == b);
				end
				K_BNE: begin
					wr = 1'b0;
					jump = (a != b);
				end
				K_JAL: begin
					v = word_t'(pc * 4 + 4);	// link
					jump = 1'b1;
				end
				default: begin
					wr = 1'b0;
					done = 1'b1;	// ebreak
				end
			endcase
			if (wr && p_rd[pc] != '0) begin
				m_reg[p_rd[pc]] = v;
				exp_rd.push_back(p_rd[pc]);
				exp_wval.push_back(v);
			end
			pc = jump ? pc + int'(p_imm[pc] >> 2) : pc + 1;
		end
	endtask

	task automatic check_level(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			value_errs++;
			$display("Fail %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic check_count(input word_t actual, input word_t expected);
		if (actual !== expected) begin
			value_errs++;
			$display("Fail num_inst: got %h, expected %h", actual, expected);
		end
	endtask

	task automatic check_reg_write(input reg_addr_t rd, input word_t value);
		if (exp_rd.size() == 0) begin
			other_errs++;
			$display("register write to x%0d but the model has no write left", rd);
		end else begin
			if (rd !== exp_rd[0]) begin
				value_errs++;
				$display("Fail rf_wa1: got %h, expected %h", rd, exp_rd[0]);
			end
			if (value !== exp_wval[0]) begin
				value_errs++;
				$display("Fail rf_wd: got %h, expected %h (x%0d)", value, exp_wval[0], rd);
			end
			void'(exp_rd.pop_front());
			void'(exp_wval.pop_front());
		end
	endtask

	task automatic check_store(input dmem_addr_t addr, input word_t data);
		if (exp_saddr.size() == 0) begin
			other_errs++;
			$display("store to word %0d but the model has no store left", addr);
		end else begin
			if (addr !== exp_saddr[0]) begin
				value_errs++;
				$display("Fail d_mem_addr: got %h, expected %h", addr, exp_saddr[0]);
			end
			if (data !== exp_sdata[0]) begin
				value_errs++;
				$display("Fail d_mem_dout: got %h, expected %h", data, exp_sdata[0]);
			end
			void'(exp_saddr.pop_front());
			void'(exp_sdata.pop_front());
		end
	endtask

	// memory reads and output checks mid cycle
	always @(negedge CLK) begin
		// read data only while the chip select is low
		i_mem_di <= (i_mem_csn === 1'b0) ? imem[i_mem_addr[`RV_IMEM_AW-1:2]] : 'x;
		rf_rd1   <= rf[rf_ra1];
		rf_rd2   <= rf[rf_ra2];
		d_mem_di <= (d_mem_csn === 1'b0) ? dmem[d_mem_addr] : 'x;
		if (RSTn === 1'b0) begin
			if (halt === 1'b1 && (rf_we === 1'b1 || d_mem_wen === 1'b0)) begin
				other_errs++;
				$display("write or store seen after halt was raised");
			end
			if (rf_we === 1'b1)
				check_reg_write(rf_wa1, rf_wd);
			if (d_mem_wen === 1'b0) begin
				check_level("d_mem_csn", d_mem_csn, 1'b0);
				if (d_mem_be !== 4'hf) begin
					value_errs++;
					$display("Fail d_mem_be: got %h, expected %h", d_mem_be, 4'hf);
				end
				check_store(d_mem_addr, d_mem_dout);
			end
		end
	end

	always @(posedge CLK) begin
		if (rf_we === 1'b1 && rf_wa1 != '0)
			rf[rf_wa1] <= rf_wd;
		if (d_mem_csn === 1'b0 && d_mem_wen === 1'b0)
			dmem[d_mem_addr] <= d_mem_dout;
	end

	initial begin
		int cycles;
		RSTn       = 1'b1;
		i_mem_di   = `RV_NOP_INSN;
		d_mem_di   = '0;
		rf_rd1     = '0;
		rf_rd2     = '0;
		value_errs = 0;
		other_errs = 0;
		rng        = 32'd14855;
		for (int r = 0; r < 32; r++)
			rf[r] = '0;
		for (int a = 0; a < DMEM_WORDS; a++) begin
			rng = xorshift(rng);
			dmem[a] = rng;
		end
		build_program();
		run_model();

		repeat (2) begin
			@(posedge CLK);
			@(negedge CLK);
			check_level("rf_we", rf_we, 1'b0);
			check_level("d_mem_wen", d_mem_wen, 1'b1);
			check_level("d_mem_csn", d_mem_csn, 1'b1);
			check_level("i_mem_csn", i_mem_csn, 1'b1);
			check_level("halt", halt, 1'b0);
			check_count(num_inst, '0);
		end
		RSTn = 1'b0;

		cycles = 0;
		while (halt !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (halt !== 1'b1) begin
			other_errs++;
			$display("timeout: halt did not rise within %0d cycles", TIMEOUT);
		end else begin
			repeat (20) begin
				@(negedge CLK);
				if (halt !== 1'b1) begin
					other_errs++;
					$display("halt dropped after it was raised");
				end
				check_level("i_mem_csn", i_mem_csn, 1'b1);
			end
			check_count(num_inst, exp_count);
			if (exp_rd.size() != 0) begin
				other_errs++;
				$display("%0d expected register writes never happened", exp_rd.size());
			end
			if (exp_saddr.size() != 0) begin
				other_errs++;
				$display("%0d expected stores never happened", exp_saddr.size());
			end
		end

		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
